// ==== design/revo_timing_pkg.sv ====
package revo_timing_pkg;

	localparam int BUNCH_WIDTH = 11;
	localparam int FRAME_WIDTH = 4;

	// frame9 marks the start of every ninth revolution
	localparam int FRAMES_PER_SUPERFRAME = 9;

	typedef logic [BUNCH_WIDTH-1:0] bunch_t;
	typedef logic [FRAME_WIDTH-1:0] frame_t;

	// receiver link alignment state
	typedef enum logic [1:0] {
		SYNC_SEARCH = 2'd0,
		SYNC_CHECK  = 2'd1,
		SYNC_LOCKED = 2'd2
	} sync_state_t;

	typedef struct packed {
		logic   revo;       // missing transition seen on the link
		logic   link_fault; // line stuck
		bunch_t bunch;
		frame_t frame;
		logic   frame9;     // bunch 0 of frame 0
	} revo_status_t;

endpackage

// ==== design/trigger_pkg.sv ====
package trigger_pkg;

	localparam int MARKER_COUNT = 4;
	localparam int PRESCALE_WIDTH = 5;
	localparam int MATCH_COUNT_WIDTH = 32;

	typedef struct packed {
		revo_timing_pkg::bunch_t                                  position;
		logic [revo_timing_pkg::FRAMES_PER_SUPERFRAME-1:0] frame_mask; // one bit per frame
	} bunch_marker_t;

	typedef bunch_marker_t [MARKER_COUNT-1:0] marker_config_t;

	// log2 of the prescale factor
	typedef logic [PRESCALE_WIDTH-1:0] prescale_t;

	typedef logic [MATCH_COUNT_WIDTH-1:0] match_count_t;

endpackage

// ==== design/revo_generator.sv ====
module revo_generator #(
	parameter int BUNCHES_PER_REVO = 40
) (
	input  logic clock,
	input  logic reset,
	output logic link_out
);
	import revo_timing_pkg::*;

	localparam bunch_t BUNCH_LAST = bunch_t'(BUNCHES_PER_REVO - 1);

	bunch_t bunch;

	always_ff @(posedge clock) begin
		if (reset) begin
			bunch <= '0;
			link_out <= 1'b0;
		end else begin
			if (bunch == BUNCH_LAST) begin
				bunch <= '0; // line holds here to mark the revo
			end else begin
				bunch <= bunch + 1'b1;
				link_out <= ~link_out;
			end
		end
	end

endmodule

// ==== design/revo_decoder.sv ====
module revo_decoder (
	input  logic clock,
	input  logic reset,
	input  logic link_in,
	output logic revo,
	output logic link_fault
);

	logic link_q;
	logic link_prev;
	logic [1:0] fill; // two real samples needed before comparing
	logic held;
	logic held_q;

	// no transition between the last two samples
	assign held = fill[1] && (link_q == link_prev);

	always_ff @(posedge clock) begin
		link_q <= link_in;
		link_prev <= link_q;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			fill <= '0;
			held_q <= 1'b0;
			revo <= 1'b0;
			link_fault <= 1'b0;
		end else begin
			fill <= {fill[0], 1'b1};
			held_q <= held;
			revo <= held && !held_q;      // first held sample only
			link_fault <= held && held_q; // held twice in a row
		end
	end

endmodule

// ==== design/revo_sync_control.sv ====
module revo_sync_control #(
	parameter int BUNCHES_PER_REVO = 40,
	parameter int PULSE_COUNT_MIN = 4
) (
	input  logic clock,
	input  logic reset,
	input  revo_timing_pkg::revo_status_t status,
	input  logic trigger_enable,
	output logic align,
	output logic frame_zero,
	output logic locked,
	output logic trigger_allowed
);
	import revo_timing_pkg::*;

	localparam bunch_t BUNCH_LAST = bunch_t'(BUNCHES_PER_REVO - 1);
	localparam int COUNT_WIDTH = $clog2(PULSE_COUNT_MIN + 1);
	localparam logic [COUNT_WIDTH-1:0] COUNT_LAST = COUNT_WIDTH'(PULSE_COUNT_MIN - 1);

	sync_state_t state;
	logic [COUNT_WIDTH-1:0] good_count;
	logic at_wrap;
	logic good_revo;
	logic lost;

	// a revo is expected exactly on the last bunch
	assign at_wrap = (status.bunch == BUNCH_LAST);
	assign good_revo = status.revo && at_wrap;

	// misplaced revo, missing revo or stuck line
	assign lost = status.link_fault || (status.revo != at_wrap);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= SYNC_SEARCH;
			good_count <= '0;
			align <= 1'b0;
			frame_zero <= 1'b0;
			locked <= 1'b0;
			trigger_allowed <= 1'b0;
		end else begin
			align <= 1'b0;
			frame_zero <= 1'b0;
			trigger_allowed <= locked && trigger_enable;
			case (state)
				SYNC_SEARCH: begin
					if (status.revo && !status.link_fault) begin
						align <= 1'b1; // counter restarts at bunch 0
						good_count <= '0;
						state <= SYNC_CHECK;
					end
				end
				SYNC_CHECK: begin
					if (lost) begin
						state <= SYNC_SEARCH;
					end else if (good_revo) begin
						if (good_count == COUNT_LAST) begin
							frame_zero <= 1'b1;
							locked <= 1'b1;
							state <= SYNC_LOCKED;
						end else begin
							good_count <= good_count + 1'b1;
						end
					end
				end
				SYNC_LOCKED: begin
					if (lost) begin
						locked <= 1'b0;
						state <= SYNC_SEARCH;
					end
				end
				default: begin
					locked <= 1'b0;
					state <= SYNC_SEARCH;
				end
			endcase
		end
	end

endmodule

// ==== design/bunch_frame_counter.sv ====
module bunch_frame_counter #(
	parameter int BUNCHES_PER_REVO = 40
) (
	input  logic clock,
	input  logic reset,
	input  logic revo,
	input  logic link_fault,
	input  logic align,
	input  logic frame_zero,
	output revo_timing_pkg::revo_status_t status
);
	import revo_timing_pkg::*;

	localparam bunch_t BUNCH_LAST = bunch_t'(BUNCHES_PER_REVO - 1);
	localparam frame_t FRAME_LAST = frame_t'(FRAMES_PER_SUPERFRAME - 1);

	bunch_t bunch_q;
	frame_t frame_q;
	bunch_t bunch_now;
	frame_t frame_now;
	frame_t frame_inc;

	assign frame_inc = (frame_q == FRAME_LAST) ? '0 : frame_q + 1'b1;

	// the strobe cycle itself is shown as bunch 0
	assign bunch_now = (align || frame_zero) ? '0 : bunch_q;
	assign frame_now = frame_zero ? '0 : frame_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			bunch_q <= '0;
			frame_q <= FRAME_LAST; // first wrap lands on frame 0
		end else if (frame_zero) begin
			bunch_q <= bunch_t'(1);
			frame_q <= '0;
		end else if (align) begin
			bunch_q <= bunch_t'(1);
			frame_q <= frame_inc;
		end else if (bunch_q == BUNCH_LAST) begin
			bunch_q <= '0;
			frame_q <= frame_inc;
		end else begin
			bunch_q <= bunch_q + 1'b1;
		end
	end

	always_comb begin
		status.revo = revo;
		status.link_fault = link_fault;
		status.bunch = bunch_now;
		status.frame = frame_now;
		status.frame9 = (bunch_now == '0) && (frame_now == '0);
	end

endmodule

// ==== design/bunch_marker_matcher.sv ====
module bunch_marker_matcher (
	input  logic clock,
	input  logic reset,
	input  revo_timing_pkg::revo_status_t status,
	input  trigger_pkg::marker_config_t markers,
	output logic match
);
	import trigger_pkg::*;

	logic [MARKER_COUNT-1:0] hit;

	always_comb begin
		for (int i = 0; i < MARKER_COUNT; i++) begin
			hit[i] = (markers[i].position == status.bunch)
				&& markers[i].frame_mask[status.frame];
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			match <= 1'b0;
		end else begin
			match <= |hit; // coincident markers give one pulse
		end
	end

endmodule

// ==== design/trigger_prescaler.sv ====
module trigger_prescaler (
	input  logic clock,
	input  logic reset,
	input  logic match,
	input  logic trigger_allowed,
	input  trigger_pkg::prescale_t prescale,
	output logic trigger
);
	import trigger_pkg::*;

	match_count_t count;
	match_count_t mask;

	// low N bits of the count
	assign mask = (match_count_t'(1) << prescale) - 1'b1;

	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
			trigger <= 1'b0;
		end else if (!trigger_allowed) begin
			count <= '0;
			trigger <= 1'b0;
		end else begin
			// fires on the 2^N-th match
			trigger <= match && ((count & mask) == mask);
			if (match) begin
				count <= count + 1'b1;
			end
		end
	end

endmodule

// ==== design/revo_timing_top.sv ====
module revo_timing_top #(
	parameter int BUNCHES_PER_REVO = 40,
	parameter int PULSE_COUNT_MIN = 4
) (
	input  logic clock,
	input  logic reset,
	input  logic link_in,
	input  logic trigger_enable,
	input  trigger_pkg::marker_config_t markers,
	input  trigger_pkg::prescale_t prescale,
	output logic link_out,
	output logic locked,
	output logic frame9,
	output logic trigger
);
	import revo_timing_pkg::*;

	revo_status_t status;
	logic revo;
	logic link_fault;
	logic align;
	logic frame_zero;
	logic trigger_allowed;
	logic match;

	assign frame9 = status.frame9;

	revo_generator #(
		.BUNCHES_PER_REVO(BUNCHES_PER_REVO)
	) u_generator (
		.clock(clock),
		.reset(reset),
		.link_out(link_out)
	);

	revo_decoder u_decoder (
		.clock(clock),
		.reset(reset),
		.link_in(link_in),
		.revo(revo),
		.link_fault(link_fault)
	);

	bunch_frame_counter #(
		.BUNCHES_PER_REVO(BUNCHES_PER_REVO)
	) u_counter (
		.clock(clock),
		.reset(reset),
		.revo(revo),
		.link_fault(link_fault),
		.align(align),
		.frame_zero(frame_zero),
		.status(status)
	);

	revo_sync_control #(
		.BUNCHES_PER_REVO(BUNCHES_PER_REVO),
		.PULSE_COUNT_MIN(PULSE_COUNT_MIN)
	) u_control (
		.clock(clock),
		.reset(reset),
		.status(status),
		.trigger_enable(trigger_enable),
		.align(align),
		.frame_zero(frame_zero),
		.locked(locked),
		.trigger_allowed(trigger_allowed)
	);

	bunch_marker_matcher u_matcher (
		.clock(clock),
		.reset(reset),
		.status(status),
		.markers(markers),
		.match(match)
	);

	trigger_prescaler u_prescaler (
		.clock(clock),
		.reset(reset),
		.match(match),
		.trigger_allowed(trigger_allowed),
		.prescale(prescale),
		.trigger(trigger)
	);

endmodule

// ==== dv/revo_timing_tb.sv ====
module revo_timing_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import revo_timing_pkg::*;
	import trigger_pkg::*;

	localparam int B = 40;
	localparam int P = 4;
	localparam int SUPERFRAME = FRAMES_PER_SUPERFRAME * B;
	localparam int LOCK_TIMEOUT = (P + 3) * B;

	logic clock = 1'b0;
	logic reset;
	logic link_in;
	logic trigger_enable;
	marker_config_t markers;
	prescale_t prescale;
	logic link_out;
	logic locked;
	logic frame9;
	logic trigger;

	logic [1:0] link_pipe = '0;
	logic tap3 = 1'b0; // 3-cycle loopback instead of 1
	logic stuck = 1'b0;
	logic [31:0] lfsr = 32'h1305_6cf5;

	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int cycle = 0;
	int mb = 0;
	int mf = 0;
	bit model_valid = 1'b0;
	bit h1 = 1'b0;
	bit h2 = 1'b0;
	bit cur_hit;
	bit align_check = 1'b0;
	int lock_age = 0;
	bit f9_seen = 1'b0;
	int f9_last = 0;
	int f9_intervals = 0;

	revo_timing_top #(
		.BUNCHES_PER_REVO(B),
		.PULSE_COUNT_MIN(P)
	) u_dut (
		.clock(clock),
		.reset(reset),
		.link_in(link_in),
		.trigger_enable(trigger_enable),
		.markers(markers),
		.prescale(prescale),
		.link_out(link_out),
		.locked(locked),
		.frame9(frame9),
		.trigger(trigger)
	);

	always #20 clock = ~clock;

	// loopback with selectable delay and a stuck fault that holds the line
	always @(posedge clock) begin
		link_pipe <= {link_pipe[0], link_out};
		if (stuck)
			link_in <= link_in;
		else if (tap3)
			link_in <= link_pipe[1];
		else
			link_in <= link_out;
	end

	function automatic bit draw_bit();
		bit fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic int draw_bits(int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
			v = (v << 1) | int'(draw_bit());
		return v;
	endfunction

	// any marker at this bunch with its frame bit set
	function automatic bit hit_at(int b, int f);
		bit h;
		h = 1'b0;
		for (int i = 0; i < MARKER_COUNT; i++)
			if (int'(markers[i].position) == b && markers[i].frame_mask[f])
				h = 1'b1;
		return h;
	endfunction

	function automatic int superframe_hits();
		int n;
		n = 0;
		for (int f = 0; f < FRAMES_PER_SUPERFRAME; f++)
			for (int b = 0; b < B; b++)
				if (hit_at(b, f))
					n++;
		return n;
	endfunction

	// bunch and frame rebuilt from frame9 to check trigger timing and frame9 spacing
	always @(posedge clock) begin
		if (frame9) begin
			mb = 0;
			mf = 0;
			model_valid = 1'b1;
		end else if (model_valid) begin
			if (mb == B - 1) begin
				mb = 0;
				mf = (mf == FRAMES_PER_SUPERFRAME - 1) ? 0 : mf + 1;
			end else begin
				mb++;
			end
		end
		cur_hit = model_valid && hit_at(mb, mf);
		if (align_check && lock_age >= 2) begin
			assert (trigger == h2) else begin
				$display("[ERROR] trigger: got %h expected %h", trigger, h2);
				errors++;
			end
		end
		h2 = h1;
		h1 = cur_hit;
		if (!locked) begin
			f9_seen = 1'b0;
		end else if (frame9) begin
			if (f9_seen) begin
				assert (cycle - f9_last == SUPERFRAME) else begin
					$display("[ERROR] frame9 interval: got %h expected %h",
						cycle - f9_last, SUPERFRAME);
					errors++;
				end
				f9_intervals++;
			end
			f9_last = cycle;
			f9_seen = 1'b1;
		end
		lock_age = locked ? ((lock_age < 1000) ? lock_age + 1 : lock_age) : 0;
		cycle++;
	end

	task automatic wait_lock();
		bit ok;
		ok = 1'b0;
		for (int i = 0; i < LOCK_TIMEOUT && !ok; i++) begin
			@(posedge clock);
			if (locked)
				ok = 1'b1;
		end
		if (!ok) begin
			$display("locked did not rise within %0d cycles", LOCK_TIMEOUT);
			errors++;
		end
	endtask

	task automatic wait_unlock();
		bit ok;
		ok = 1'b0;
		for (int i = 0; i < 2 * B && !ok; i++) begin
			@(posedge clock);
			if (!locked)
				ok = 1'b1;
		end
		if (!ok) begin
			$display("locked did not fall within %0d cycles", 2 * B);
			errors++;
		end
	endtask

	// called right at the cycle locked is seen high
	task automatic count_triggers(output int n);
		n = 0;
		@(posedge clock);
		for (int i = 0; i < SUPERFRAME; i++) begin
			@(posedge clock);
			if (trigger)
				n++;
		end
	endtask

	task automatic check_count(string name, int got, int expected);
		assert (got == expected) else begin
			$display("[ERROR] %s: got %h expected %h", name, got, expected);
			errors++;
		end
	endtask

	task automatic report_test(string name, int errors_before);
		tests_run++;
		if (errors != errors_before) begin
			tests_failed++;
			$display("test %0d %s: failed", tests_run, name);
		end else begin
			$display("test %0d %s: ok", tests_run, name);
		end
	endtask

	initial begin
		int e;
		int n;
		int hits;
		reset = 1'b1;
		link_in = 1'b0;
		trigger_enable = 1'b0;
		prescale = '0;
		markers = '0;
		for (int i = 0; i < MARKER_COUNT; i++) begin
			markers[i].position = bunch_t'(draw_bits(6) % B);
			markers[i].frame_mask = 9'(draw_bits(9));
		end
		hits = superframe_hits();
		$display("marker hits per superframe: %0d", hits);

		e = errors;
		repeat (10) @(posedge clock);
		assert (link_out == 1'b0) else begin
			$display("[ERROR] link_out in reset: got %h expected %h", link_out, 1'b0);
			errors++;
		end
		reset <= 1'b0;
		trigger_enable <= 1'b1;
		@(posedge clock);
		@(posedge clock);
		assert (!locked && !frame9 && !trigger) else begin
			$display("[ERROR] outputs after reset: locked %h frame9 %h trigger %h",
				locked, frame9, trigger);
			errors++;
		end
		wait_lock();
		report_test("reset and lock", e);

		e = errors;
		align_check = 1'b1;
		count_triggers(n);
		align_check = 1'b0;
		check_count("triggers prescale 0", n, hits);
		report_test("trigger timing and count", e);

		e = errors;
		for (int i = 0; i < 3 * SUPERFRAME && f9_intervals < 2; i++)
			@(posedge clock);
		if (f9_intervals < 2) begin
			$display("too few frame9 pulses seen while locked");
			errors++;
		end
		report_test("frame9 spacing", e);

		e = errors;
		stuck <= 1'b1;
		wait_unlock();
		count_triggers(n);
		check_count("triggers while stuck", n, 0);
		prescale <= prescale_t'(2);
		stuck <= 1'b0;
		wait_lock();
		count_triggers(n);
		check_count("triggers prescale 2", n, hits >> 2);
		report_test("stuck link and prescale", e);

		e = errors;
		prescale <= '0;
		trigger_enable <= 1'b0;
		repeat (3) @(posedge clock);
		count_triggers(n);
		check_count("triggers while disabled", n, 0);
		trigger_enable <= 1'b1;
		tap3 <= 1'b1;
		wait_unlock();
		wait_lock();
		align_check = 1'b1;
		count_triggers(n);
		align_check = 1'b0;
		check_count("triggers after tap change", n, hits);
		report_test("enable and relock", e);

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== files.f ====
design/revo_timing_pkg.sv
design/trigger_pkg.sv
design/revo_generator.sv
design/revo_decoder.sv
design/revo_sync_control.sv
design/bunch_frame_counter.sv
design/bunch_marker_matcher.sv
design/trigger_prescaler.sv
design/revo_timing_top.sv
dv/revo_timing_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run with Verilator, pass is decided from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f \
	--top-module revo_timing_tb -o sim_revo_timing &&
./obj_dir/sim_revo_timing > sim.log 2>&1
cat sim.log 2>/dev/null

grep -qx "PASS: all tests" sim.log && echo "simulation passed" || {
	echo "simulation failed"
	exit 1
}
